// File: logic/wr_path_pkg.sv
package wr_path_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ID_WIDTH   = 4;
  // AXI4 awlen is always eight bits
  localparam int LEN_WIDTH  = 8;

  // memory chunk geometry, one chunk is four 32-bit beats
  localparam int CHUNK_BEATS = 4;
  localparam int CHUNK_BYTES = 16;

  // AXI encodings
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] RESP_OKAY  = 2'b00;

  typedef logic [ID_WIDTH-1:0] id_t;

  // one memory write command per chunk
  // seq is low on the first chunk of a burst
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    id_t                   id;
    logic                  seq;
  } mem_cmd_t;

  // one buffered write beat
  typedef struct packed {
    logic [STRB_WIDTH-1:0] strb;
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } wr_beat_t;

endpackage

// File: logic/burst_req_if.sv
`timescale 1ns/1ps

// one accepted AXI write burst, handed from the capture FSM to the chunker
interface burst_req_if;

  logic                                valid;
  logic                                ready;
  logic [wr_path_pkg::ADDR_WIDTH-1:0]  addr;
  wr_path_pkg::id_t                    id;
  logic [wr_path_pkg::LEN_WIDTH-1:0]   len;

  // capture FSM side
  modport source (
    output valid,
    output addr,
    output id,
    output len,
    input  ready
  );

  // chunker side
  modport sink (
    input  valid,
    input  addr,
    input  id,
    input  len,
    output ready
  );

endinterface

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clock,
  input  logic reset,

  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,

  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  // storage, written only when there is room
  always_ff @(posedge clock) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count moves only when exactly one side fires
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/burst_chunker.sv
`timescale 1ns/1ps

module burst_chunker (
  input  logic                  clock,
  input  logic                  reset,

  burst_req_if.sink             req,

  output logic                  cmd_valid_o,
  input  logic                  cmd_ready_i,
  output wr_path_pkg::mem_cmd_t cmd_o
);

  localparam int SHIFT = $clog2(wr_path_pkg::CHUNK_BEATS);
  // (len+1)/CHUNK_BEATS reaches 256/4 for the longest AXI4 burst
  localparam int CNT_W = wr_path_pkg::LEN_WIDTH + 1 - SHIFT;

  logic [wr_path_pkg::ADDR_WIDTH-1:0] addr_q;
  wr_path_pkg::id_t                   id_q;
  logic [CNT_W-1:0]                   remain_q;
  logic                               first_q;

  logic [wr_path_pkg::LEN_WIDTH:0]    beats;
  logic [CNT_W-1:0]                   chunks;
  logic                               req_fire;
  logic                               cmd_fire;

  assign beats  = {1'b0, req.len} + 1'b1;
  assign chunks = beats[wr_path_pkg::LEN_WIDTH:SHIFT];

  // a new burst is taken only once the previous one is fully issued
  assign req.ready = (remain_q == '0);
  assign req_fire  = req.valid && req.ready;

  assign cmd_valid_o = (remain_q != '0);
  assign cmd_fire    = cmd_valid_o && cmd_ready_i;

  assign cmd_o.addr = addr_q;
  assign cmd_o.id   = id_q;
  assign cmd_o.seq  = !first_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      remain_q <= '0;
      first_q  <= 1'b0;
    end else if (req_fire) begin
      remain_q <= chunks;
      first_q  <= 1'b1;
    end else if (cmd_fire) begin
      remain_q <= remain_q - 1'b1;
      first_q  <= 1'b0;
    end
  end

  // chunk address, stepped on each command handshake
  always_ff @(posedge clock) begin
    if (req_fire) begin
      addr_q <= req.addr;
      id_q   <= req.id;
    end else if (cmd_fire) begin
      addr_q <= addr_q + wr_path_pkg::ADDR_WIDTH'(wr_path_pkg::CHUNK_BYTES);
    end
  end

endmodule

// File: logic/wr_capture_fsm.sv
`timescale 1ns/1ps

module wr_capture_fsm #(
  parameter int MAX_PENDING = 4
) (
  input  logic                               clock,
  input  logic                               reset,

  input  logic                               awvalid_i,
  output logic                               awready_o,
  input  logic [wr_path_pkg::ADDR_WIDTH-1:0] awaddr_i,
  input  wr_path_pkg::id_t                   awid_i,
  input  logic [wr_path_pkg::LEN_WIDTH-1:0]  awlen_i,

  input  logic                               wvalid_i,
  output logic                               wready_o,
  input  logic                               wlast_i,
  input  logic                               beat_ready_i,

  burst_req_if.source                        req,

  output logic                               id_push_o,
  input  logic                               id_ready_i,

  input  logic                               done_i,
  output logic                               bvalid_o,
  input  logic                               bready_i,
  output logic [1:0]                         bresp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_BUSY
  } state_t;

  localparam int PEND_W = $clog2(MAX_PENDING + 1);

  state_t            state_q;
  logic              aw_fire;
  logic              wlast_fire;
  logic              b_fire;
  logic [PEND_W-1:0] pending_q;

  // AW only when the chunker is free and the response ID can be queued
  assign awready_o = (state_q == ST_IDLE) && req.ready && id_ready_i;
  assign wready_o  = (state_q == ST_FILL) && beat_ready_i;

  assign aw_fire    = awvalid_i && awready_o;
  assign wlast_fire = wvalid_i && wready_o && wlast_i;
  assign id_push_o  = aw_fire;

  always_ff @(posedge clock) begin
    if (reset) begin
      // start in BUSY so AW stays closed for the first cycle out of reset
      state_q <= ST_BUSY;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (aw_fire) begin
            state_q <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (wlast_fire) begin
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          // wait for room in the data FIFO
          if (beat_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_BUSY;
        end
      endcase
    end
  end

  // burst request towards the chunker
  always_ff @(posedge clock) begin
    if (reset) begin
      req.valid <= 1'b0;
    end else if (aw_fire) begin
      req.valid <= 1'b1;
    end else if (req.ready) begin
      req.valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) begin
      req.addr <= awaddr_i;
      req.id   <= awid_i;
      req.len  <= awlen_i;
    end
  end

  // completed bursts still owed a B response
  assign b_fire = bvalid_o && bready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending_q <= '0;
    end else if (done_i && !b_fire) begin
      pending_q <= pending_q + 1'b1;
    end else if (b_fire && !done_i) begin
      pending_q <= pending_q - 1'b1;
    end
  end

  assign bvalid_o = (pending_q != '0);
  assign bresp_o  = wr_path_pkg::RESP_OKAY;

endmodule

// File: logic/axi_wr_path.sv
`timescale 1ns/1ps

module axi_wr_path #(
  parameter int CMD_DEPTH  = 16,
  parameter int DATA_DEPTH = 64
) (
  input  logic                               clock,
  input  logic                               reset,

  // AXI4 write address
  input  logic                               axi_awvalid_i,
  output logic                               axi_awready_o,
  input  logic [wr_path_pkg::ADDR_WIDTH-1:0] axi_awaddr_i,
  input  logic [wr_path_pkg::ID_WIDTH-1:0]   axi_awid_i,
  input  logic [wr_path_pkg::LEN_WIDTH-1:0]  axi_awlen_i,
  // only INCR is supported, so the burst type is not looked at
  input  logic [1:0]                         axi_awburst_i,

  // AXI4 write data
  input  logic                               axi_wvalid_i,
  output logic                               axi_wready_o,
  input  logic [wr_path_pkg::DATA_WIDTH-1:0] axi_wdata_i,
  input  logic [wr_path_pkg::STRB_WIDTH-1:0] axi_wstrb_i,
  input  logic                               axi_wlast_i,

  // AXI4 write response
  output logic                               axi_bvalid_o,
  input  logic                               axi_bready_i,
  output logic [1:0]                         axi_bresp_o,
  output logic [wr_path_pkg::ID_WIDTH-1:0]   axi_bid_o,

  // memory command port
  output logic                               mem_store_o,
  input  logic                               mem_accept_i,
  output logic                               mem_wseq_o,
  output logic [wr_path_pkg::ID_WIDTH-1:0]   mem_wrid_o,
  output logic [wr_path_pkg::ADDR_WIDTH-1:0] mem_addr_o,

  // memory data port
  output logic                               mem_valid_o,
  input  logic                               mem_ready_i,
  output logic                               mem_last_o,
  output logic [wr_path_pkg::STRB_WIDTH-1:0] mem_strb_o,
  output logic [wr_path_pkg::DATA_WIDTH-1:0] mem_data_o
);

  // one ID slot per burst waiting for its response
  localparam int ID_DEPTH = 4;

  burst_req_if req_if ();

  logic                  chunk_valid;
  logic                  chunk_ready;
  wr_path_pkg::mem_cmd_t chunk_cmd;
  wr_path_pkg::mem_cmd_t mem_cmd;

  wr_path_pkg::wr_beat_t beat_in;
  wr_path_pkg::wr_beat_t beat_out;
  logic                  beat_ready;

  logic                  id_push;
  logic                  id_ready;

  assign beat_in.strb = axi_wstrb_i;
  assign beat_in.data = axi_wdata_i;
  assign beat_in.last = axi_wlast_i;

  assign mem_addr_o = mem_cmd.addr;
  assign mem_wrid_o = mem_cmd.id;
  assign mem_wseq_o = mem_cmd.seq;

  assign mem_strb_o = beat_out.strb;
  assign mem_data_o = beat_out.data;
  assign mem_last_o = beat_out.last;

  wr_capture_fsm #(
    .MAX_PENDING (ID_DEPTH)
  ) u_capture (
    .clock        (clock),
    .reset        (reset),
    .awvalid_i    (axi_awvalid_i),
    .awready_o    (axi_awready_o),
    .awaddr_i     (axi_awaddr_i),
    .awid_i       (axi_awid_i),
    .awlen_i      (axi_awlen_i),
    .wvalid_i     (axi_wvalid_i),
    .wready_o     (axi_wready_o),
    .wlast_i      (axi_wlast_i),
    .beat_ready_i (beat_ready),
    .req          (req_if.source),
    .id_push_o    (id_push),
    .id_ready_i   (id_ready),
    .done_i       (mem_valid_o & mem_ready_i & mem_last_o),
    .bvalid_o     (axi_bvalid_o),
    .bready_i     (axi_bready_i),
    .bresp_o      (axi_bresp_o)
  );

  burst_chunker u_chunker (
    .clock       (clock),
    .reset       (reset),
    .req         (req_if.sink),
    .cmd_valid_o (chunk_valid),
    .cmd_ready_i (chunk_ready),
    .cmd_o       (chunk_cmd)
  );

  sync_fifo #(
    .T     (wr_path_pkg::mem_cmd_t),
    .DEPTH (CMD_DEPTH)
  ) u_cmd_fifo (
    .clock   (clock),
    .reset   (reset),
    .valid_i (chunk_valid),
    .ready_o (chunk_ready),
    .data_i  (chunk_cmd),
    .valid_o (mem_store_o),
    .ready_i (mem_accept_i),
    .data_o  (mem_cmd)
  );

  // whole bursts are buffered here, so W can run ahead of the memory
  sync_fifo #(
    .T     (wr_path_pkg::wr_beat_t),
    .DEPTH (DATA_DEPTH)
  ) u_data_fifo (
    .clock   (clock),
    .reset   (reset),
    .valid_i (axi_wvalid_i & axi_wready_o),
    .ready_o (beat_ready),
    .data_i  (beat_in),
    .valid_o (mem_valid_o),
    .ready_i (mem_ready_i),
    .data_o  (beat_out)
  );

  // the head entry is always the ID of the oldest unanswered burst
  sync_fifo #(
    .T     (wr_path_pkg::id_t),
    .DEPTH (ID_DEPTH)
  ) u_id_fifo (
    .clock   (clock),
    .reset   (reset),
    .valid_i (id_push),
    .ready_o (id_ready),
    .data_i  (axi_awid_i),
    .valid_o (),
    .ready_i (axi_bvalid_o & axi_bready_i),
    .data_o  (axi_bid_o)
  );

endmodule

// File: dv/axi_wr_path_tb.sv
`timescale 1ns/1ps

module axi_wr_path_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int NUM_BURSTS   = 40;
  localparam int MAX_BEATS    = 16;
  localparam int DRAIN_CYCLES = 200;
  localparam longint WATCHDOG_NS = NUM_BURSTS * MAX_BEATS * 10 * CLK_PERIOD;

  logic clock = 1'b0;
  logic reset;
  logic axi_awvalid_i, axi_awready_o;
  logic [31:0] axi_awaddr_i;
  logic [3:0] axi_awid_i;
  logic [7:0] axi_awlen_i;
  logic [1:0] axi_awburst_i;
  logic axi_wvalid_i, axi_wready_o, axi_wlast_i;
  logic [31:0] axi_wdata_i;
  logic [3:0] axi_wstrb_i;
  logic axi_bvalid_o, axi_bready_i;
  logic [1:0] axi_bresp_o;
  logic [3:0] axi_bid_o;
  logic mem_store_o, mem_accept_i, mem_wseq_o;
  logic [3:0] mem_wrid_o;
  logic [31:0] mem_addr_o;
  logic mem_valid_o, mem_ready_i, mem_last_o;
  logic [3:0] mem_strb_o;
  logic [31:0] mem_data_o;

  integer seed = 95;
  int cycle = 0;
  int cmd_errs = 0;
  int data_errs = 0;
  int resp_errs = 0;
  int proto_errs = 0;
  int cmd_count = 0;
  int beat_count = 0;
  int resp_count = 0;

  // expected traffic as seen on the AXI side
  wr_path_pkg::mem_cmd_t cmd_q[$];
  wr_path_pkg::wr_beat_t beat_q[$];
  wr_path_pkg::id_t id_q[$];

  // values seen just before each rising edge and the queue heads they meet
  logic s_aw_hs = 0;
  logic s_w_hs = 0;
  logic s_cmd_hs = 0;
  logic s_mem_hs = 0;
  logic s_b_hs = 0;
  logic s_awready = 0;
  logic s_wready = 0;
  logic s_bvalid = 0;
  logic s_bready = 0;
  logic [1:0] s_bresp = 0;
  logic [3:0] s_bid = 0;
  wr_path_pkg::mem_cmd_t s_cmd = '0;
  wr_path_pkg::mem_cmd_t exp_cmd = '0;
  wr_path_pkg::wr_beat_t s_beat = '0;
  wr_path_pkg::wr_beat_t exp_beat = '0;
  wr_path_pkg::id_t exp_bid = '0;
  logic exp_cmd_ok = 0;
  logic exp_beat_ok = 0;
  logic exp_bid_ok = 0;

  axi_wr_path #(
    .CMD_DEPTH  (16),
    .DATA_DEPTH (64)
  ) UUT (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic show_mismatch(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
  endtask

  // monitor samples one nanosecond before each rising edge
  always begin
    @(negedge clock);
    #(CLK_PERIOD / 2 - 1);
    s_aw_hs = axi_awvalid_i && axi_awready_o;
    s_w_hs = axi_wvalid_i && axi_wready_o;
    s_cmd_hs = mem_store_o && mem_accept_i;
    s_mem_hs = mem_valid_o && mem_ready_i;
    s_b_hs = axi_bvalid_o && axi_bready_i;
    s_awready = axi_awready_o;
    s_wready = axi_wready_o;
    s_bvalid = axi_bvalid_o;
    s_bready = axi_bready_i;
    s_bresp = axi_bresp_o;
    s_bid = axi_bid_o;
    s_cmd = '{addr: mem_addr_o, id: mem_wrid_o, seq: mem_wseq_o};
    s_beat = '{strb: mem_strb_o, data: mem_data_o, last: mem_last_o};
    exp_cmd_ok = (cmd_q.size() != 0);
    exp_beat_ok = (beat_q.size() != 0);
    exp_bid_ok = (id_q.size() != 0);
    if (exp_cmd_ok) exp_cmd = cmd_q[0];
    if (exp_beat_ok) exp_beat = beat_q[0];
    if (exp_bid_ok) exp_bid = id_q[0];
    if (!reset) begin
      if (s_cmd_hs) begin
        cmd_count++;
        if (exp_cmd_ok) void'(cmd_q.pop_front());
      end
      if (s_mem_hs) begin
        beat_count++;
        if (exp_beat_ok) void'(beat_q.pop_front());
      end
      if (s_b_hs) begin
        resp_count++;
        if (exp_bid_ok) void'(id_q.pop_front());
      end
      if (s_aw_hs) begin
        // one command per four beats with seq low only on the first
        for (int k = 0; k < (axi_awlen_i + 1) / 4; k++) begin
          cmd_q.push_back('{addr: axi_awaddr_i + 32'(16 * k), id: axi_awid_i,
                            seq: (k != 0)});
        end
        id_q.push_back(axi_awid_i);
      end
      if (s_w_hs) begin
        beat_q.push_back('{strb: axi_wstrb_i, data: axi_wdata_i, last: axi_wlast_i});
      end
    end
  end

  a_cmd_known: assert property (@(posedge clock) disable iff (reset) s_cmd_hs |-> exp_cmd_ok)
    else begin
      cmd_errs++;
      $display("memory command at t=%0t with no command expected", $time);
    end
  a_cmd_addr: assert property (@(posedge clock) disable iff (reset)
    s_cmd_hs && exp_cmd_ok |-> s_cmd.addr == exp_cmd.addr)
    else begin
      cmd_errs++;
      show_mismatch("mem_addr_o", exp_cmd.addr, s_cmd.addr);
    end
  a_cmd_id: assert property (@(posedge clock) disable iff (reset)
    s_cmd_hs && exp_cmd_ok |-> s_cmd.id == exp_cmd.id)
    else begin
      cmd_errs++;
      show_mismatch("mem_wrid_o", exp_cmd.id, s_cmd.id);
    end
  a_cmd_seq: assert property (@(posedge clock) disable iff (reset)
    s_cmd_hs && exp_cmd_ok |-> s_cmd.seq == exp_cmd.seq)
    else begin
      cmd_errs++;
      show_mismatch("mem_wseq_o", exp_cmd.seq, s_cmd.seq);
    end

  a_beat_known: assert property (@(posedge clock) disable iff (reset) s_mem_hs |-> exp_beat_ok)
    else begin
      data_errs++;
      $display("memory data beat at t=%0t with no beat expected", $time);
    end
  a_beat_data: assert property (@(posedge clock) disable iff (reset)
    s_mem_hs && exp_beat_ok |-> s_beat.data == exp_beat.data)
    else begin
      data_errs++;
      show_mismatch("mem_data_o", exp_beat.data, s_beat.data);
    end
  a_beat_strb: assert property (@(posedge clock) disable iff (reset)
    s_mem_hs && exp_beat_ok |-> s_beat.strb == exp_beat.strb)
    else begin
      data_errs++;
      show_mismatch("mem_strb_o", exp_beat.strb, s_beat.strb);
    end
  a_beat_last: assert property (@(posedge clock) disable iff (reset)
    s_mem_hs && exp_beat_ok |-> s_beat.last == exp_beat.last)
    else begin
      data_errs++;
      show_mismatch("mem_last_o", exp_beat.last, s_beat.last);
    end

  a_resp_known: assert property (@(posedge clock) disable iff (reset) s_b_hs |-> exp_bid_ok)
    else begin
      resp_errs++;
      $display("write response at t=%0t with no burst outstanding", $time);
    end
  a_resp_id: assert property (@(posedge clock) disable iff (reset)
    s_b_hs && exp_bid_ok |-> s_bid == exp_bid)
    else begin
      resp_errs++;
      show_mismatch("axi_bid_o", exp_bid, s_bid);
    end
  a_resp_okay: assert property (@(posedge clock) disable iff (reset)
    s_bvalid |-> s_bresp == wr_path_pkg::RESP_OKAY)
    else begin
      resp_errs++;
      show_mismatch("axi_bresp_o", wr_path_pkg::RESP_OKAY, s_bresp);
    end
  a_resp_hold: assert property (@(posedge clock) disable iff (reset)
    s_bvalid && !s_bready |=> s_bvalid && s_bid == $past(s_bid))
    else begin
      resp_errs++;
      $display("axi_bvalid_o or axi_bid_o changed at t=%0t before bready", $time);
    end
  a_aw_w_apart: assert property (@(posedge clock) disable iff (reset) !(s_awready && s_wready))
    else begin
      proto_errs++;
      $display("awready and wready both high at t=%0t", $time);
    end

  // memory sink and B ready are random with fixed stall windows
  always @(negedge clock) begin
    cycle++;
    mem_accept_i = ({$random(seed)} % 4 != 0) && !(cycle >= 600 && cycle < 720);
    mem_ready_i = ({$random(seed)} % 4 != 0) && !(cycle >= 250 && cycle < 450);
    axi_bready_i = ({$random(seed)} % 3 != 0) && !(cycle >= 850 && cycle < 1000);
  end

  task automatic send_aw(input logic [31:0] addr, input logic [3:0] id, input int beats);
    axi_awvalid_i = 1'b1;
    axi_awaddr_i = addr;
    axi_awid_i = id;
    axi_awlen_i = 8'(beats - 1);
    do @(negedge clock); while (!s_aw_hs);
    axi_awvalid_i = 1'b0;
  endtask

  task automatic send_beats(input int beats);
    int gap;
    for (int b = 0; b < beats; b++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) @(negedge clock);
      axi_wvalid_i = 1'b1;
      axi_wdata_i = $random(seed);
      axi_wstrb_i = 4'($random(seed));
      axi_wlast_i = (b == beats - 1);
      do @(negedge clock); while (!s_w_hs);
      axi_wvalid_i = 1'b0;
      axi_wlast_i = 1'b0;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns: %0d of %0d responses seen", WATCHDOG_NS, resp_count,
             NUM_BURSTS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int beats;
    int drain;
    int total;
    logic [31:0] addr;
    reset = 1'b1;
    axi_awvalid_i = 1'b0;
    axi_awaddr_i = '0;
    axi_awid_i = '0;
    axi_awlen_i = '0;
    axi_awburst_i = wr_path_pkg::BURST_INCR;
    axi_wvalid_i = 1'b0;
    axi_wdata_i = '0;
    axi_wstrb_i = '0;
    axi_wlast_i = 1'b0;
    axi_bready_i = 1'b0;
    mem_accept_i = 1'b0;
    mem_ready_i = 1'b0;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    a_reset_quiet: assert (!axi_awready_o && !axi_wready_o && !axi_bvalid_o &&
                           !mem_store_o && !mem_valid_o)
      else begin
        proto_errs++;
        $display("a ready or valid output is high right after reset");
      end

    for (int i = 0; i < NUM_BURSTS; i++) begin
      beats = 4 << ({$random(seed)} % 3);
      // aligned to the burst size so that no burst crosses 4 KB
      addr = $random(seed) & ~32'(beats * 4 - 1);
      repeat ({$random(seed)} % 3) @(negedge clock);
      send_aw(addr, 4'($random(seed)), beats);
      send_beats(beats);
    end

    while (resp_count < NUM_BURSTS) @(negedge clock);
    drain = 0;
    while (drain < DRAIN_CYCLES && (cmd_q.size() != 0 || beat_q.size() != 0)) begin
      @(negedge clock);
      drain++;
    end
    repeat (4) @(negedge clock);
    a_all_drained: assert (cmd_q.size() == 0 && beat_q.size() == 0 && id_q.size() == 0)
      else begin
        proto_errs++;
        $display("%0d commands, %0d beats and %0d responses never came out",
                 cmd_q.size(), beat_q.size(), id_q.size());
      end
    a_all_idle: assert (!mem_store_o && !mem_valid_o && !axi_bvalid_o)
      else begin
        proto_errs++;
        $display("the DUT still offers traffic after the last response");
      end

    total = cmd_errs + data_errs + resp_errs + proto_errs;
    $display("errors cmd %0d data %0d resp %0d proto %0d (%0d cmds, %0d beats, %0d resps)",
             cmd_errs, data_errs, resp_errs, proto_errs, cmd_count, beat_count, resp_count);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
logic/wr_path_pkg.sv
logic/burst_req_if.sv
logic/sync_fifo.sv
logic/burst_chunker.sv
logic/wr_capture_fsm.sv
logic/axi_wr_path.sv
dv/axi_wr_path_tb.sv

// File: Makefile
# Verilator run of the AXI write path testbench
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= axi_wr_path_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "test: PASS"; \
	else \
	  echo "test: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
